// File: bench/afe_checker.sv
// Output checker comparing DUT samples, DAC codes and bus responses with expected values
`timescale 1ns/1ns
`default_nettype none

module afe_checker (
  input  logic                adc_clk,
  // Watched DUT outputs
  input  afe_pkg::smp_pair_t  adc_smp_i,
  input  afe_pkg::code_pair_t dac_dat_i,
  input  afe_pkg::sys_rsp_t   sys_rsp_i,
  // Expected values and enables from the stimulus side
  input  afe_pkg::smp_pair_t  exp_smp_i,
  input  afe_pkg::code_pair_t exp_code_i,
  input  afe_pkg::sys_rsp_t   exp_rsp_i,
  input  logic                smp_chk_i,
  input  logic                code_chk_i,
  input  logic                rsp_chk_i,   // ack and err
  input  logic                rdat_chk_i,  // rdata, plain reads only
  output int                  data_err_o,
  output int                  bus_err_o
);

  int n_data = 0;  // Stream and code mismatches
  int n_bus  = 0;  // Response mismatches

  assign data_err_o = n_data;
  assign bus_err_o  = n_bus;

  //////////////////////////////////////////////////////////
  // Compare on the rising edge, before the DUT updates
  //////////////////////////////////////////////////////////

  always @(posedge adc_clk)
  begin
    if (smp_chk_i && (adc_smp_i !== exp_smp_i))
    begin
      n_data++;
      $display("CHECK FAILED @%0t ns: adc_smp a=%0d b=%0d, expected a=%0d b=%0d", $time,
               adc_smp_i.ch_a, adc_smp_i.ch_b, exp_smp_i.ch_a, exp_smp_i.ch_b);
    end
    if (code_chk_i && (dac_dat_i !== exp_code_i))
    begin
      n_data++;
      $display("CHECK FAILED @%0t ns: dac_dat a=%h b=%h, expected a=%h b=%h", $time,
               dac_dat_i.ch_a, dac_dat_i.ch_b, exp_code_i.ch_a, exp_code_i.ch_b);
    end
    // Handshake flags
    if (rsp_chk_i && ((sys_rsp_i.ack !== exp_rsp_i.ack) || (sys_rsp_i.err !== exp_rsp_i.err)))
    begin
      n_bus++;
      $display("CHECK FAILED @%0t ns: ack/err %b/%b, expected %b/%b", $time,
               sys_rsp_i.ack, sys_rsp_i.err, exp_rsp_i.ack, exp_rsp_i.err);
    end
    if (rdat_chk_i && (sys_rsp_i.rdata !== exp_rsp_i.rdata))
    begin
      n_bus++;
      $display("CHECK FAILED @%0t ns: rdata %h, expected %h", $time,
               sys_rsp_i.rdata, exp_rsp_i.rdata);
    end
  end

endmodule

`default_nettype wire

// File: bench/afe_properties.sv
// Bus response assertions for the housekeeping register block, attached by bind
`timescale 1ns/1ns
`default_nettype none

module afe_properties (
  input logic              adc_clk,
  input logic              rst_n_i,
  input afe_pkg::sys_req_t sys_req_i,  // Strobes into the block
  input afe_pkg::sys_rsp_t sys_rsp_i   // Response out of the block
);

  int fail_cnt = 0;  // Collected at end of run

  // Single-cycle ack pulse
  ack_pulse: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_rsp_i.ack |=> !sys_rsp_i.ack)
  else
  begin
    $error("ack stayed high for two consecutive cycles");
    fail_cnt++;
  end

  // No error without ack
  err_with_ack: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_rsp_i.err |-> sys_rsp_i.ack)
  else
  begin
    $error("err raised without ack");
    fail_cnt++;
  end

  // Each strobe answered on the next edge
  strobe_ack: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (sys_req_i.wen || sys_req_i.ren) |=> sys_rsp_i.ack)
  else
  begin
    $error("strobe not followed by ack in the next cycle");
    fail_cnt++;
  end

endmodule

bind hk_regs afe_properties i_props (
  .adc_clk   (adc_clk  ),
  .rst_n_i   (rst_n_i  ),
  .sys_req_i (sys_req_i),
  .sys_rsp_i (sys_rsp_o)
);

`default_nettype wire

// File: bench/afe_tb.sv
// Testbench top with clock, reset, stimulus table, bus tasks, watchdog and final verdict
`timescale 1ns/1ns
`default_nettype none

module afe_tb;

  import afe_pkg::*;

  localparam logic [31:0] ID_VAL = 32'h5250_0001;
  localparam int          N_RAND = 16;  // Random rows after fixed ones

  typedef struct packed {
    raw_pair_t  raw;
    smp_pair_t  gen;
    smp_pair_t  ctl;
    smp_pair_t  adc;   // Converted capture
    smp_pair_t  sum;   // Clipped gen + ctl
    code_pair_t code;  // DAC code of the clipped sum
  } row_t;

  logic        adc_clk = 1'b0;
  logic        rst_n;
  raw_pair_t   adc_raw;
  smp_pair_t   gen_dat;
  smp_pair_t   ctl_dat;
  sys_req_t    sys_req;
  smp_pair_t   adc_smp;
  code_pair_t  dac_dat;
  sys_rsp_t    sys_rsp;
  smp_pair_t   exp_smp;
  code_pair_t  exp_code;
  sys_rsp_t    exp_rsp;
  logic        smp_chk;
  logic        code_chk;
  logic        rsp_chk;
  logic        rdat_chk;
  int          data_err;
  int          bus_err;
  int          asrt_err;
  row_t        tbl[$];
  logic [31:0] rng = 32'h86295f2f;
  logic        tbl_ready = 1'b0;

  always #10 adc_clk = ~adc_clk;  // 20 ns period

  afe_top #(
    .HK_ID (ID_VAL)
  ) UUT (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n  ),
    .adc_raw_i (adc_raw),
    .gen_dat_i (gen_dat),
    .ctl_dat_i (ctl_dat),
    .sys_req_i (sys_req),
    .adc_smp_o (adc_smp),
    .dac_dat_o (dac_dat),
    .sys_rsp_o (sys_rsp)
  );

  afe_checker i_checker (
    .adc_clk    (adc_clk ),
    .adc_smp_i  (adc_smp ),
    .dac_dat_i  (dac_dat ),
    .sys_rsp_i  (sys_rsp ),
    .exp_smp_i  (exp_smp ),
    .exp_code_i (exp_code),
    .exp_rsp_i  (exp_rsp ),
    .smp_chk_i  (smp_chk ),
    .code_chk_i (code_chk),
    .rsp_chk_i  (rsp_chk ),
    .rdat_chk_i (rdat_chk),
    .data_err_o (data_err),
    .bus_err_o  (bus_err )
  );

  ////////////////////////////////////////////////////////////
  // Reference arithmetic
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Upper 14 bits, code 0 is +8191 and full scale is -8192
  function automatic int raw_to_val(input logic [15:0] raw);
    return 8191 - int'(raw >> 2);
  endfunction

  function automatic int clamp_sum(input int a, input int b);
    int s;
    s = a + b;
    if (s > 8191)
    begin
      s = 8191;
    end
    else if (s < -8192)
    begin
      s = -8192;
    end
    return s;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  task automatic add_row(input logic [15:0] ra, input logic [15:0] rb,
                         input int ga, input int gb, input int ca, input int cb,
                         input int aa, input int ab, input int sa, input int sb);
    row_t r;
    r.raw.ch_a  = ra;
    r.raw.ch_b  = rb;
    r.gen.ch_a  = smp_t'(ga);
    r.gen.ch_b  = smp_t'(gb);
    r.ctl.ch_a  = smp_t'(ca);
    r.ctl.ch_b  = smp_t'(cb);
    r.adc.ch_a  = smp_t'(aa);
    r.adc.ch_b  = smp_t'(ab);
    r.sum.ch_a  = smp_t'(sa);
    r.sum.ch_b  = smp_t'(sb);
    r.code.ch_a = code_t'(8191 - sa);  // Same negative slope as the ADC
    r.code.ch_b = code_t'(8191 - sb);
    tbl.push_back(r);
  endtask

  task automatic build_table();
    logic [31:0] r;
    int          ga;
    int          gb;
    int          ca;
    int          cb;
    // raw a/b, gen a/b, ctl a/b, expected adc a/b, expected sum a/b
    add_row(16'hFFFF, 16'h0000, 0, 0, 0, 0, -8192, 8191, 0, 0);            // All ones, zeros
    add_row(16'h7FFC, 16'h8000, 8191, -8192, 1, -1, 0, -1, 8191, -8192);   // Mid-scale, overflow
    add_row(16'h0003, 16'hFFFC, 8000, -8000, 191, -192, 8191, -8192, 8191, -8192); // Extremes
    add_row(16'h4000, 16'hC000, -8192, 8191, -8192, 8191, 4095, -4097, -8192, 8191);
    add_row(16'h1234, 16'hABCD, 100, -1, -50, 0, 7026, -2804, 50, -1);    // No clipping
    for (int k = 0; k < N_RAND; k++)
    begin
      rng = next_rand(rng);
      r   = rng;
      rng = next_rand(rng);
      ga  = $signed(rng[13:0]);
      gb  = $signed(rng[27:14]);
      rng = next_rand(rng);
      ca  = $signed(rng[13:0]);
      cb  = $signed(rng[27:14]);
      add_row(r[15:0], r[31:16], ga, gb, ca, cb, raw_to_val(r[15:0]), raw_to_val(r[31:16]),
              clamp_sum(ga, ca), clamp_sum(gb, cb));
    end
  endtask

  // Codes lag by one row, samples too unless looped back
  task automatic run_table(input logic loop_on);
    int n;
    n = tbl.size();
    for (int i = 0; i <= n; i++)
    begin
      @(negedge adc_clk);
      if (i < n)
      begin
        adc_raw = tbl[i].raw;
        gen_dat = tbl[i].gen;
        ctl_dat = tbl[i].ctl;
      end
      code_chk = (i > 0);
      if (i > 0)
      begin
        exp_code = tbl[i-1].code;
      end
      if (loop_on)
      begin
        smp_chk = (i < n);
        if (i < n)
        begin
          exp_smp = tbl[i].sum;  // Same-cycle loopback
        end
      end
      else
      begin
        smp_chk = (i > 0);
        if (i > 0)
        begin
          exp_smp = tbl[i-1].adc;
        end
      end
    end
    @(negedge adc_clk);
    smp_chk  = 1'b0;
    code_chk = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Bus access, ack expected one cycle after the strobe
  ////////////////////////////////////////////////////////////

  task automatic bus_op(input logic wr, input logic [SYS_AW-1:0] addr,
                        input logic [SYS_DW-1:0] data, input logic exp_err);
    @(negedge adc_clk);
    sys_req.addr  = addr;
    sys_req.wdata = wr ? data : '0;
    sys_req.wen   = wr;
    sys_req.ren   = !wr;
    @(negedge adc_clk);
    sys_req       = '0;
    exp_rsp.ack   = 1'b1;
    exp_rsp.err   = exp_err;
    exp_rsp.rdata = data;
    rsp_chk       = 1'b1;
    rdat_chk      = !wr && !exp_err;  // Only good reads carry data
    @(negedge adc_clk);
    rsp_chk       = 1'b0;
    rdat_chk      = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    rst_n    = 1'b0;
    adc_raw  = '0;
    gen_dat  = '0;
    ctl_dat  = '0;
    sys_req  = '0;
    exp_smp  = '0;
    exp_code = '0;
    exp_rsp  = '0;
    smp_chk  = 1'b0;
    code_chk = 1'b0;
    rsp_chk  = 1'b0;
    rdat_chk = 1'b0;
    build_table();
    tbl_ready = 1'b1;
    repeat (5) @(negedge adc_clk);

    // Reset values seen on the first edge after release
    rst_n         = 1'b1;
    exp_smp       = '1;  // -1 on both channels
    exp_code.ch_a = 14'h1FFF;
    exp_code.ch_b = 14'h1FFF;
    exp_rsp       = '0;
    smp_chk       = 1'b1;
    code_chk      = 1'b1;
    rsp_chk       = 1'b1;
    rdat_chk      = 1'b1;
    @(negedge adc_clk);
    smp_chk  = 1'b0;
    code_chk = 1'b0;
    rsp_chk  = 1'b0;
    rdat_chk = 1'b0;

    run_table(1'b0);

    // ID, unmapped read, ID write
    bus_op(1'b0, REG_ID, ID_VAL, 1'b0);
    bus_op(1'b0, 20'h0C, 32'h0, 1'b1);
    bus_op(1'b1, REG_ID, 32'hFFFF_FFFF, 1'b1);
    bus_op(1'b0, REG_ID, ID_VAL, 1'b0);  // Still intact

    // Sticky clip status on channel A
    @(negedge adc_clk);
    gen_dat = '0;
    ctl_dat = '0;
    bus_op(1'b1, REG_SAT, 32'h3, 1'b0);  // Table rows left bits set
    bus_op(1'b0, REG_SAT, 32'h0, 1'b0);
    @(negedge adc_clk);
    gen_dat.ch_a = 14'sd8191;
    ctl_dat.ch_a = 14'sd1;               // One cycle of overflow
    @(negedge adc_clk);
    gen_dat = '0;
    ctl_dat = '0;
    bus_op(1'b0, REG_SAT, 32'h1, 1'b0);
    @(negedge adc_clk);
    gen_dat.ch_a = 14'sd10;
    ctl_dat.ch_a = 14'sd20;
    bus_op(1'b0, REG_SAT, 32'h1, 1'b0);  // Bit survives
    bus_op(1'b1, REG_SAT, 32'h1, 1'b0);
    bus_op(1'b0, REG_SAT, 32'h0, 1'b0);

    // Loopback on, then back to conversion
    bus_op(1'b1, REG_CTRL, 32'h1, 1'b0);
    bus_op(1'b0, REG_CTRL, 32'h1, 1'b0);
    run_table(1'b1);
    bus_op(1'b1, REG_CTRL, 32'h0, 1'b0);
    bus_op(1'b0, REG_CTRL, 32'h0, 1'b0);
    run_table(1'b0);

    @(negedge adc_clk);
    asrt_err = UUT.i_hk_regs.i_props.fail_cnt;
    $display("Errors: data %0d, bus %0d, assertions %0d", data_err, bus_err, asrt_err);
    if ((data_err + bus_err + asrt_err) == 0)
    begin
      $display(">>> PASS");
    end
    else
    begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog, generous margin over the table
  initial
  begin
    wait (tbl_ready);
    repeat (tbl.size() + 200) @(posedge adc_clk);
    $display("Timeout: run did not finish within %0d cycles", tbl.size() + 200);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
logic/afe_pkg.sv
logic/adc_front.sv
logic/dac_back.sv
logic/hk_regs.sv
logic/afe_top.sv
bench/afe_properties.sv
bench/afe_checker.sv
bench/afe_tb.sv

// File: logic/adc_front.sv
// ADC input register, offset-to-two's-complement conversion and digital loopback select
`timescale 1ns/1ns
`default_nettype none

module adc_front (
  input  logic                adc_clk,
  input  logic                rst_n_i,
  input  afe_pkg::raw_pair_t  adc_raw_i,  // Straight from the pins
  input  afe_pkg::smp_pair_t  sat_dat_i,  // Clipped DAC values
  input  logic                loop_en_i,  // From housekeeping
  output afe_pkg::smp_pair_t  adc_smp_o
);

  import afe_pkg::*;

  // 0x8000 on the pins, upper 14 bits only
  localparam code_t RAW_RST = code_t'(16'h8000 >> (ADC_RAW_W - SMP_W));

  code_pair_t adc_reg;  // Captured raw codes
  smp_pair_t  adc_cnv;  // After slope conversion

  //////////////////////////////////////////////////////////
  // Capture
  //////////////////////////////////////////////////////////

  // Meant to map onto the IO block flops
  // Two LSBs belong to a 16-bit part and are dropped
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      adc_reg.ch_a <= RAW_RST;  // Reads back as -1
      adc_reg.ch_b <= RAW_RST;
    end
    else
    begin
      adc_reg.ch_a <= adc_raw_i.ch_a[ADC_RAW_W-1 -: SMP_W];
      adc_reg.ch_b <= adc_raw_i.ch_b[ADC_RAW_W-1 -: SMP_W];
    end
  end

  //////////////////////////////////////////////////////////
  // Conversion and loopback
  //////////////////////////////////////////////////////////

  // Negative slope, mid-scale offset
  always_comb
  begin
    adc_cnv.ch_a = code_to_smp(adc_reg.ch_a);
    adc_cnv.ch_b = code_to_smp(adc_reg.ch_b);
  end

  // Loopback bypasses the capture flops entirely,
  // so the clipped sum shows up in the same cycle
  always_comb
  begin
    if (loop_en_i)
    begin
      adc_smp_o = sat_dat_i;  // Internal test path
    end
    else
    begin
      adc_smp_o = adc_cnv;    // Normal acquisition
    end
  end

endmodule

`default_nettype wire

// File: logic/afe_pkg.sv
// Analog front-end shared widths, sample and code types, pair and bus structs, register map
`default_nettype none

package afe_pkg;

  //////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////

  parameter int ADC_RAW_W = 16;  // Raw converter word, 2 LSBs unused
  parameter int SMP_W     = 14;  // Sample and DAC code
  parameter int SUM_W     = 15;  // Generator + controller, before clipping

  parameter int SYS_AW = 20;  // System bus address
  parameter int SYS_DW = 32;  // System bus data

  //////////////////////////////////////////////////////////
  // Data path types
  //////////////////////////////////////////////////////////

  typedef logic signed [SMP_W-1:0] smp_t;  // Two's complement
  typedef logic        [SMP_W-1:0] code_t; // Negative slope, offset binary

  // Mid-scale code, sample value zero
  parameter code_t CODE_ZERO = 14'h1FFF;

  // Channel B sits in the upper half, channel A in the lower
  typedef struct packed {
    logic [ADC_RAW_W-1:0] ch_b;
    logic [ADC_RAW_W-1:0] ch_a;
  } raw_pair_t;

  typedef struct packed {
    smp_t ch_b;
    smp_t ch_a;
  } smp_pair_t;

  typedef struct packed {
    code_t ch_b;
    code_t ch_a;
  } code_pair_t;

  // Per-channel clip flag, ch_a is bit 0
  typedef struct packed {
    logic ch_b;
    logic ch_a;
  } sat_t;

  //////////////////////////////////////////////////////////
  // System bus
  //////////////////////////////////////////////////////////

  typedef struct packed {
    logic [SYS_AW-1:0] addr;
    logic [SYS_DW-1:0] wdata;
    logic              wen;   // Single-cycle write strobe
    logic              ren;   // Single-cycle read strobe
  } sys_req_t;

  typedef struct packed {
    logic [SYS_DW-1:0] rdata;
    logic              ack;   // One cycle after strobe
    logic              err;
  } sys_rsp_t;

  parameter logic [SYS_AW-1:0] REG_ID   = 20'h00;  // Read only
  parameter logic [SYS_AW-1:0] REG_CTRL = 20'h04;  // Bit 0 loopback
  parameter logic [SYS_AW-1:0] REG_SAT  = 20'h08;  // Sticky clip, W1C

  // Negative slope code to two's complement
  function automatic smp_t code_to_smp(input code_t code);
    return smp_t'({code[SMP_W-1], ~code[SMP_W-2:0]});  // Keep MSB, flip the rest
  endfunction

  // Same flip back toward the converter
  function automatic code_t smp_to_code(input smp_t smp);
    return {smp[SMP_W-1], ~smp[SMP_W-2:0]};
  endfunction

endpackage

`default_nettype wire

// File: logic/afe_top.sv
// Analog front-end top level connecting ADC front, DAC back and housekeeping registers
`timescale 1ns/1ns
`default_nettype none

module afe_top #(
  parameter logic [31:0] HK_ID = 32'h0000_0000  // Passed to housekeeping
) (
  input  logic                adc_clk,
  input  logic                rst_n_i,    // Async, active low
  // Converter side
  input  afe_pkg::raw_pair_t  adc_raw_i,
  input  afe_pkg::smp_pair_t  gen_dat_i,  // Generator stream in
  input  afe_pkg::smp_pair_t  ctl_dat_i,  // Controller stream in
  // System bus
  input  afe_pkg::sys_req_t   sys_req_i,
  // Streams and codes out
  output afe_pkg::smp_pair_t  adc_smp_o,
  output afe_pkg::code_pair_t dac_dat_o,
  output afe_pkg::sys_rsp_t   sys_rsp_o
);

  import afe_pkg::*;

  smp_pair_t sat_dat;  // Clipped DAC sum, loopback source
  sat_t      sat_hit;  // Clip pulses into status
  logic      loop_en;  // Digital loopback enable

  //////////////////////////////////////////////////////////
  // Acquisition side
  //////////////////////////////////////////////////////////

  adc_front i_adc_front (
    .adc_clk   (adc_clk  ),
    .rst_n_i   (rst_n_i  ),
    .adc_raw_i (adc_raw_i),
    .sat_dat_i (sat_dat  ),  // From DAC path
    .loop_en_i (loop_en  ),
    .adc_smp_o (adc_smp_o)
  );

  //////////////////////////////////////////////////////////
  // Generation side
  //////////////////////////////////////////////////////////

  dac_back i_dac_back (
    .adc_clk   (adc_clk  ),  // Same clock drives the DAC
    .rst_n_i   (rst_n_i  ),
    .gen_dat_i (gen_dat_i),
    .ctl_dat_i (ctl_dat_i),
    .sat_dat_o (sat_dat  ),
    .sat_hit_o (sat_hit  ),
    .dac_dat_o (dac_dat_o)
  );

  //////////////////////////////////////////////////////////
  // Housekeeping
  //////////////////////////////////////////////////////////

  hk_regs #(
    .HK_ID (HK_ID)
  ) i_hk_regs (
    .adc_clk   (adc_clk  ),
    .rst_n_i   (rst_n_i  ),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .sat_hit_i (sat_hit  ),
    .loop_en_o (loop_en  )
  );

endmodule

`default_nettype wire

// File: logic/dac_back.sv
// DAC path summing generator and controller, saturating, converting to code and registering
`timescale 1ns/1ns
`default_nettype none

module dac_back (
  input  logic                adc_clk,
  input  logic                rst_n_i,
  input  afe_pkg::smp_pair_t  gen_dat_i,  // Signal generator stream
  input  afe_pkg::smp_pair_t  ctl_dat_i,  // Controller stream
  output afe_pkg::smp_pair_t  sat_dat_o,  // Clipped sum, also feeds loopback
  output afe_pkg::sat_t       sat_hit_o,  // Clip this cycle
  output afe_pkg::code_pair_t dac_dat_o   // Registered converter codes
);

  import afe_pkg::*;

  logic signed [SUM_W-1:0] sum_a;
  logic signed [SUM_W-1:0] sum_b;

  // Overflow shows as a mismatch of the two top bits
  function automatic logic clip(input logic signed [SUM_W-1:0] sum);
    return sum[SUM_W-1] ^ sum[SUM_W-2];
  endfunction

  // Clamp to +8191 / -8192 on overflow, else drop the extra bit
  function automatic smp_t saturate(input logic signed [SUM_W-1:0] sum);
    smp_t res;
    if (clip(sum))
    begin
      res = smp_t'({sum[SUM_W-1], {(SMP_W-1){~sum[SUM_W-1]}}});
    end
    else
    begin
      res = sum[SMP_W-1:0];
    end
    return res;
  endfunction

  //////////////////////////////////////////////////////////
  // Sum and saturation
  //////////////////////////////////////////////////////////

  // Both operands signed, extended to 15 bits
  assign sum_a = gen_dat_i.ch_a + ctl_dat_i.ch_a;
  assign sum_b = gen_dat_i.ch_b + ctl_dat_i.ch_b;

  always_comb
  begin
    sat_dat_o.ch_a = saturate(sum_a);
    sat_dat_o.ch_b = saturate(sum_b);
  end

  // Pulse per channel, housekeeping makes it sticky
  always_comb
  begin
    sat_hit_o.ch_a = clip(sum_a);
    sat_hit_o.ch_b = clip(sum_b);
  end

  //////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////

  // Converter wants negative slope offset code
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_o.ch_a <= CODE_ZERO;  // Analog zero out of reset
      dac_dat_o.ch_b <= CODE_ZERO;
    end
    else
    begin
      dac_dat_o.ch_a <= smp_to_code(sat_dat_o.ch_a);
      dac_dat_o.ch_b <= smp_to_code(sat_dat_o.ch_b);
    end
  end

endmodule

`default_nettype wire

// File: logic/hk_regs.sv
// Housekeeping register block on the system bus with ID, loopback control and clip status
`timescale 1ns/1ns
`default_nettype none

module hk_regs #(
  parameter logic [31:0] HK_ID = 32'h0000_0000  // Build identification
) (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  afe_pkg::sys_req_t sys_req_i,
  output afe_pkg::sys_rsp_t sys_rsp_o,
  input  afe_pkg::sat_t     sat_hit_i,  // Clip pulses from DAC path
  output logic              loop_en_o
);

  import afe_pkg::*;

  logic              loop_en;   // REG_CTRL bit 0
  sat_t              sat_sts;   // REG_SAT bits 1:0
  sat_t              sat_clr;   // W1C mask this cycle
  logic              strobe;
  logic              hit_id;
  logic              hit_ctrl;
  logic              hit_sat;
  logic              bad;
  logic [SYS_DW-1:0] rd_mux;

  //////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////

  assign hit_id   = (sys_req_i.addr == REG_ID);
  assign hit_ctrl = (sys_req_i.addr == REG_CTRL);
  assign hit_sat  = (sys_req_i.addr == REG_SAT);

  assign strobe = sys_req_i.wen | sys_req_i.ren;

  // Unmapped, or an attempt to overwrite the ID
  assign bad = !(hit_id || hit_ctrl || hit_sat) || (sys_req_i.wen && hit_id);

  // Read data, zero for anything unmapped
  always_comb
  begin
    case (sys_req_i.addr)
      REG_ID:   rd_mux = HK_ID;
      REG_CTRL: rd_mux = SYS_DW'(loop_en);
      REG_SAT:  rd_mux = SYS_DW'(sat_sts);
      default:  rd_mux = '0;
    endcase
  end

  //////////////////////////////////////////////////////////
  // Control and status
  //////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      loop_en <= 1'b0;
    end
    else if (sys_req_i.wen && hit_ctrl)
    begin
      loop_en <= sys_req_i.wdata[0];  // Upper bits ignored
    end
  end

  // Only a write to REG_SAT clears anything
  assign sat_clr = (sys_req_i.wen && hit_sat) ? sat_t'(sys_req_i.wdata[1:0]) : sat_t'(2'b00);

  // Sticky, a new clip beats a clear in the same cycle
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sat_sts <= '0;
    end
    else
    begin
      sat_sts <= sat_t'((sat_sts & ~sat_clr) | sat_hit_i);
    end
  end

  assign loop_en_o = loop_en;

  //////////////////////////////////////////////////////////
  // Bus response
  //////////////////////////////////////////////////////////

  // Everything answers one cycle after the strobe
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sys_rsp_o <= '0;
    end
    else
    begin
      sys_rsp_o.ack <= strobe;
      sys_rsp_o.err <= strobe & bad;   // Always paired with ack
      if (sys_req_i.ren)
      begin
        sys_rsp_o.rdata <= rd_mux;
      end
      else
      begin
        sys_rsp_o.rdata <= '0;         // Writes return nothing
      end
    end
  end

endmodule

`default_nettype wire
